//--- filelist.f
source/mgmt_regs_pkg.sv
source/mgmt_write_decoder.sv
source/relay_control.sv
source/front_panel_control.sv
source/mgmt_read_mux.sv
source/trigger_mgmt_top.sv
testbench/tb_trigger_mgmt.sv

//--- Makefile
VERILATOR	= verilator
VFLAGS		= --binary --timing
LINT_FLAGS	= --lint-only --timing
TOP			= tb_trigger_mgmt
RTL_TOP		= trigger_mgmt_top
FILELIST	= filelist.f
BUILD_DIR	= obj_dir
LOG			= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only if the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^ALL CHECKS PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_trigger_mgmt.sv
`timescale 1ns/1ps

module tb_trigger_mgmt
	import mgmt_regs_pkg::*;
();

	typedef logic [NUM_CHANNELS-1:0]	chan_vec_t;
	typedef logic [NUM_RELAYS-1:0]		relay_vec_t;

	// Sample limit for every read completion
	localparam int READ_TIMEOUT = 50;

	//////////////////////////////////////////////////
	// DUT signals

	logic							clk;
	logic							reset;
	logic							rd_en;
	mgmt_addr_t						rd_addr;
	logic							rd_valid;
	mgmt_byte_t						rd_data;
	logic							wr_en;
	mgmt_addr_t						wr_addr;
	mgmt_byte_t						wr_data;
	logic							die_serial_valid;
	logic [NUM_SERIAL_BYTES*8-1:0]	die_serial;
	logic							idcode_valid;
	logic [NUM_IDCODE_BYTES*8-1:0]	idcode;
	sensor_word_t					sensor_words [6];
	logic							relay_en;
	logic							relay_dir;
	relay_idx_t						relay_channel;
	logic							relay_done;
	chan_vec_t						trig_in_led;
	chan_vec_t						trig_out_led;
	muxsel_t [NUM_CHANNELS-1:0]		muxsel;
	logic							front_shift_en;
	mgmt_byte_t						front_shift_data;
	logic							front_shift_done;
	logic							front_cs_n;

	// Expected state kept by the testbench
	muxsel_t						exp_mux [NUM_CHANNELS];
	relay_vec_t						relay_input_mode;

	trigger_mgmt_top UUT (
		.clk				(clk),
		.reset				(reset),
		.rd_en				(rd_en),
		.rd_addr			(rd_addr),
		.rd_valid			(rd_valid),
		.rd_data			(rd_data),
		.wr_en				(wr_en),
		.wr_addr			(wr_addr),
		.wr_data			(wr_data),
		.die_serial_valid	(die_serial_valid),
		.die_serial			(die_serial),
		.idcode_valid		(idcode_valid),
		.idcode				(idcode),
		.fan0_rpm			(sensor_words[0]),
		.fan1_rpm			(sensor_words[1]),
		.die_temp			(sensor_words[2]),
		.volt_core			(sensor_words[3]),
		.volt_ram			(sensor_words[4]),
		.volt_aux			(sensor_words[5]),
		.relay_en			(relay_en),
		.relay_dir			(relay_dir),
		.relay_channel		(relay_channel),
		.relay_done			(relay_done),
		.trig_in_led		(trig_in_led),
		.trig_out_led		(trig_out_led),
		.muxsel				(muxsel),
		.front_shift_en		(front_shift_en),
		.front_shift_data	(front_shift_data),
		.front_shift_done	(front_shift_done),
		.front_cs_n			(front_cs_n)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Failure reporting and compares

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string test, input mgmt_byte_t expected,
			input mgmt_byte_t actual);
		if (actual !== expected)
			abort_run($sformatf("Fail: %s expected 0x%02h actual 0x%02h",
				test, expected, actual));
	endtask

	task automatic check_muxsel(input string test, input muxsel_t expected,
			input muxsel_t actual);
		if (actual !== expected)
			abort_run($sformatf("Fail: %s expected 0x%01h actual 0x%01h",
				test, expected, actual));
	endtask

	task automatic check_relay_channel(input string test, input relay_idx_t expected,
			input relay_idx_t actual);
		if (actual !== expected)
			abort_run($sformatf("Fail: %s expected %0d actual %0d",
				test, expected, actual));
	endtask

	task automatic check_bit(input string test, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("Fail: %s expected %b actual %b", test, expected, actual));
	endtask

	// Whole selector bank against the model
	task automatic compare_muxsel_bank(input string test);
		for (int i = 0; i < NUM_CHANNELS; i++)
			check_muxsel($sformatf("%s ch %0d", test, i), exp_mux[i], muxsel[i]);
	endtask

	//////////////////////////////////////////////////
	// Expected values from the register rules

	// MSB first, byte n of the group at base + n
	function automatic mgmt_byte_t idcode_byte(input int n);
		return mgmt_byte_t'(idcode >> (8 * (NUM_IDCODE_BYTES - 1 - n)));
	endfunction

	function automatic mgmt_byte_t serial_byte(input int n);
		return mgmt_byte_t'(die_serial >> (8 * (NUM_SERIAL_BYTES - 1 - n)));
	endfunction

	// Reversed input LEDs on top, output LEDs below with relay inputs dark
	function automatic led_state_t expected_led(input chan_vec_t in_led,
			input chan_vec_t out_led, input relay_vec_t input_mode);
		led_state_t led;
		led = '0;
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			led[NUM_CHANNELS + i]	= in_led[NUM_CHANNELS - 1 - i];
			led[i]					= out_led[i];
		end
		for (int k = 0; k < NUM_RELAYS; k++) begin
			if (input_mode[k])
				led[RELAY_FIRST_CHANNEL + k] = 1'b0;
		end
		return led;
	endfunction

	//////////////////////////////////////////////////
	// Bus and handshake tasks

	// One-cycle write strobe, returns right after the capturing edge
	task automatic host_write(input mgmt_addr_t addr, input mgmt_byte_t data);
		@(posedge clk);
		wr_en	<= 1'b1;
		wr_addr	<= addr;
		wr_data	<= data;
		@(posedge clk);
		wr_en	<= 1'b0;
	endtask

	// rd_addr stays put until the next read
	task automatic issue_read(input mgmt_addr_t addr);
		@(posedge clk);
		rd_en	<= 1'b1;
		rd_addr	<= addr;
		@(posedge clk);
		rd_en	<= 1'b0;
	endtask

	task automatic wait_read_valid(output mgmt_byte_t data);
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (!rd_valid && waited >= READ_TIMEOUT)
				abort_run($sformatf("Timeout: no rd_valid within %0d cycles", READ_TIMEOUT));
		end while (!rd_valid);
		data = rd_data;
	endtask

	task automatic host_read(input mgmt_addr_t addr, output mgmt_byte_t data);
		issue_read(addr);
		wait_read_valid(data);
	endtask

	task automatic wait_relay_en(input int max_cycles);
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (!relay_en && waited >= max_cycles)
				abort_run($sformatf("Timeout: relay_en did not pulse within %0d cycles",
					max_cycles));
		end while (!relay_en);
	endtask

	task automatic wait_front_shift(input int max_cycles);
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (!front_shift_en && waited >= max_cycles)
				abort_run($sformatf("Timeout: front_shift_en did not pulse within %0d cycles",
					max_cycles));
		end while (!front_shift_en);
	endtask

	task automatic pulse_relay_done();
		@(posedge clk);
		relay_done <= 1'b1;
		@(posedge clk);
		relay_done <= 1'b0;
	endtask

	task automatic pulse_shift_done();
		@(posedge clk);
		front_shift_done <= 1'b1;
		@(posedge clk);
		front_shift_done <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_state();
		@(negedge clk);
		check_bit("reset rd_valid", 1'b0, rd_valid);
		check_bit("reset relay_en", 1'b0, relay_en);
		check_bit("reset front_shift_en", 1'b0, front_shift_en);
		check_bit("reset front_cs_n", 1'b1, front_cs_n);
		check_byte("reset rd_data", 8'h00, rd_data);
		compare_muxsel_bank("reset muxsel");
	endtask

	task automatic test_device_info();
		mgmt_byte_t data;
		// IDCODE read held off while the group is not valid
		issue_read(REG_FPGA_IDCODE + 16'd1);
		repeat (10) begin
			@(negedge clk);
			check_bit("idcode wait rd_valid", 1'b0, rd_valid);
		end
		@(posedge clk);
		idcode_valid <= 1'b1;
		wait_read_valid(data);
		check_byte("idcode byte 1 after wait", idcode_byte(1), data);
		for (int n = 0; n < NUM_IDCODE_BYTES; n++) begin
			host_read(REG_FPGA_IDCODE + mgmt_addr_t'(n), data);
			check_byte($sformatf("idcode byte %0d", n), idcode_byte(n), data);
		end

		// Same for the die serial
		issue_read(REG_FPGA_SERIAL);
		repeat (3) begin
			@(negedge clk);
			check_bit("serial wait rd_valid", 1'b0, rd_valid);
		end
		@(posedge clk);
		die_serial_valid <= 1'b1;
		wait_read_valid(data);
		check_byte("serial byte 0 after wait", serial_byte(0), data);
		for (int n = 0; n < NUM_SERIAL_BYTES; n++) begin
			host_read(REG_FPGA_SERIAL + mgmt_addr_t'(n), data);
			check_byte($sformatf("serial byte %0d", n), serial_byte(n), data);
		end
	endtask

	task automatic test_sensor_reads();
		mgmt_byte_t data;
		mgmt_addr_t addr;
		for (int s = 0; s < 6; s++) begin
			addr = REG_FAN0_RPM + mgmt_addr_t'(2 * s);
			host_read(addr, data);
			check_byte($sformatf("sensor %0d low", s), sensor_words[s][7:0], data);
			host_read(addr + 16'd1, data);
			check_byte($sformatf("sensor %0d high", s), sensor_words[s][15:8], data);
		end
		host_read(16'h0030, data);
		check_byte("unmapped 0x0030", 8'h00, data);
		host_read(REG_RELAY_STAT, data);
		check_byte("relay stat low", 8'h00, data);
		// High address bits must not alias onto the sensors
		host_read(16'h8010, data);
		check_byte("unmapped 0x8010", 8'h00, data);
	endtask

	task automatic test_mux_selectors();
		mgmt_byte_t data;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			data		= mgmt_byte_t'($urandom);
			exp_mux[ch]	= data[MUXSEL_W-1:0];
			host_write(REG_MUXSEL_BASE + mgmt_addr_t'(ch), data);
			@(negedge clk);
			compare_muxsel_bank($sformatf("muxsel write ch %0d", ch));
		end
		// Slot above the last channel
		host_write(16'h00fd, mgmt_byte_t'($urandom));
		@(negedge clk);
		compare_muxsel_bank("muxsel write 0x00fd");
	endtask

	task automatic test_relay_command();
		mgmt_byte_t data;
		host_write(REG_RELAY_TOGGLE, 8'h02);
		host_write(REG_RELAY_TOGGLE_1, 8'h80);
		// Exactly one cycle after the toggle write
		wait_relay_en(1);
		check_relay_channel("relay channel", 2'd2, relay_channel);
		check_bit("relay dir", 1'b1, relay_dir);
		@(negedge clk);
		check_bit("relay_en single cycle", 1'b0, relay_en);
		relay_input_mode[2] = 1'b1;

		host_read(REG_RELAY_STAT_1, data);
		check_byte("relay busy", 8'h01, data);
		pulse_relay_done();
		host_read(REG_RELAY_STAT_1, data);
		check_byte("relay idle after done", 8'h00, data);
	endtask

	task automatic test_front_panel();
		mgmt_byte_t	data;
		mgmt_byte_t	raw;
		chan_vec_t	in_led;
		chan_vec_t	out_led;
		led_state_t	exp_led;

		host_write(REG_FRONT_CTRL, 8'h00);
		@(negedge clk);
		check_bit("front cs low", 1'b0, front_cs_n);

		// Raw byte through the shifter
		raw = mgmt_byte_t'($urandom);
		host_write(REG_FRONT_DATA, raw);
		wait_front_shift(1);
		check_byte("front raw data", raw, front_shift_data);
		@(negedge clk);
		check_bit("front_shift_en single cycle", 1'b0, front_shift_en);
		host_read(REG_FRONT_STAT, data);
		check_byte("front busy", 8'h01, data);
		host_read(REG_FRONT_STAT, data);
		check_byte("front still busy", 8'h01, data);
		pulse_shift_done();
		host_read(REG_FRONT_STAT, data);
		check_byte("front idle after done", 8'h00, data);

		// LED pushes, output LED of relay 2 forced on
		in_led	= chan_vec_t'($urandom);
		out_led	= chan_vec_t'($urandom) | chan_vec_t'(1 << (RELAY_FIRST_CHANNEL + 2));
		@(posedge clk);
		trig_in_led		<= in_led;
		trig_out_led	<= out_led;
		exp_led = expected_led(in_led, out_led, relay_input_mode);
		for (int n = 0; n < NUM_LED_BYTES; n++) begin
			host_write(REG_FRONT_LED_0 + mgmt_addr_t'(n), mgmt_byte_t'($urandom));
			wait_front_shift(1);
			check_byte($sformatf("led push %0d", n), exp_led[n*DATA_W +: DATA_W],
				front_shift_data);
			// LED bit 10 is bit 2 of byte 1
			if (n == 1)
				check_bit("led relay 2 masked", 1'b0, front_shift_data[2]);
			pulse_shift_done();
		end

		host_write(REG_FRONT_CTRL, 8'h01);
		@(negedge clk);
		check_bit("front cs high", 1'b1, front_cs_n);

		// Relay and panel writes leave the selector bank alone
		compare_muxsel_bank("muxsel after other writes");
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(32'hac48_a361));

		reset				= 1'b1;
		rd_en				= 1'b0;
		rd_addr				= '0;
		wr_en				= 1'b0;
		wr_addr				= '0;
		wr_data				= '0;
		relay_done			= 1'b0;
		front_shift_done	= 1'b0;
		trig_in_led			= '0;
		trig_out_led		= '0;
		idcode_valid		= 1'b0;
		die_serial_valid	= 1'b0;
		idcode				= $urandom;
		die_serial			= {$urandom, $urandom};
		for (int s = 0; s < 6; s++)
			sensor_words[s] = sensor_word_t'($urandom);
		for (int i = 0; i < NUM_CHANNELS; i++)
			exp_mux[i] = '0;
		relay_input_mode	= '0;

		repeat (4) @(posedge clk);
		reset <= 1'b0;

		test_reset_state();
		test_device_info();
		test_sensor_reads();
		test_mux_selectors();
		test_relay_command();
		test_front_panel();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- source/trigger_mgmt_top.sv
`timescale 1ns/1ps

module trigger_mgmt_top
	import mgmt_regs_pkg::*;
(
	input  logic							clk,
	input  logic							reset,

	// Host read
	input  logic							rd_en,
	input  mgmt_addr_t						rd_addr,
	output logic							rd_valid,
	output mgmt_byte_t						rd_data,

	// Host write
	input  logic							wr_en,
	input  mgmt_addr_t						wr_addr,
	input  mgmt_byte_t						wr_data,

	// Device information
	input  logic							die_serial_valid,
	input  logic [NUM_SERIAL_BYTES*8-1:0]	die_serial,
	input  logic							idcode_valid,
	input  logic [NUM_IDCODE_BYTES*8-1:0]	idcode,

	// Sensors
	input  sensor_word_t					fan0_rpm,
	input  sensor_word_t					fan1_rpm,
	input  sensor_word_t					die_temp,
	input  sensor_word_t					volt_core,
	input  sensor_word_t					volt_ram,
	input  sensor_word_t					volt_aux,

	// Relays
	output logic							relay_en,
	output logic							relay_dir,
	output relay_idx_t						relay_channel,
	input  logic							relay_done,

	// Indicators and crossbar
	input  logic [NUM_CHANNELS-1:0]			trig_in_led,
	input  logic [NUM_CHANNELS-1:0]			trig_out_led,
	output muxsel_t [NUM_CHANNELS-1:0]		muxsel,

	// Front panel shifter
	output logic							front_shift_en,
	output mgmt_byte_t						front_shift_data,
	input  logic							front_shift_done,
	output logic							front_cs_n
);

	//////////////////////////////////////////////////
	// Internal strobes and status

	mgmt_byte_t					wr_byte;
	logic						relay_chan_wr;
	logic						relay_toggle_wr;
	logic						front_ctrl_wr;
	logic						front_data_wr;
	logic						led_push_wr;
	logic [1:0]					led_push_sel;
	logic						relay_busy;
	logic [NUM_RELAYS-1:0]		relay_state_vec;
	logic						front_busy;

	// Write decode and selector bank
	mgmt_write_decoder u_write (
		.clk				(clk),
		.reset				(reset),
		.wr_en				(wr_en),
		.wr_addr			(wr_addr),
		.wr_data			(wr_data),
		.muxsel				(muxsel),
		.wr_byte			(wr_byte),
		.relay_chan_wr		(relay_chan_wr),
		.relay_toggle_wr	(relay_toggle_wr),
		.front_ctrl_wr		(front_ctrl_wr),
		.front_data_wr		(front_data_wr),
		.led_push_wr		(led_push_wr),
		.led_push_sel		(led_push_sel)
	);

	relay_control u_relay (
		.clk				(clk),
		.reset				(reset),
		.wr_byte			(wr_byte),
		.relay_chan_wr		(relay_chan_wr),
		.relay_toggle_wr	(relay_toggle_wr),
		.relay_en			(relay_en),
		.relay_channel		(relay_channel),
		.relay_dir			(relay_dir),
		.relay_done			(relay_done),
		.relay_busy			(relay_busy),
		.relay_state_vec	(relay_state_vec)
	);

	front_panel_control u_front (
		.clk				(clk),
		.reset				(reset),
		.wr_byte			(wr_byte),
		.front_ctrl_wr		(front_ctrl_wr),
		.front_data_wr		(front_data_wr),
		.led_push_wr		(led_push_wr),
		.led_push_sel		(led_push_sel),
		.trig_in_led		(trig_in_led),
		.trig_out_led		(trig_out_led),
		.relay_state_vec	(relay_state_vec),
		.front_cs_n			(front_cs_n),
		.front_shift_en		(front_shift_en),
		.front_shift_data	(front_shift_data),
		.front_shift_done	(front_shift_done),
		.front_busy			(front_busy)
	);

	// Read path
	mgmt_read_mux u_read (
		.clk				(clk),
		.reset				(reset),
		.rd_en				(rd_en),
		.rd_addr			(rd_addr),
		.rd_valid			(rd_valid),
		.rd_data			(rd_data),
		.idcode_valid		(idcode_valid),
		.idcode				(idcode),
		.die_serial_valid	(die_serial_valid),
		.die_serial			(die_serial),
		.fan0_rpm			(fan0_rpm),
		.fan1_rpm			(fan1_rpm),
		.die_temp			(die_temp),
		.volt_core			(volt_core),
		.volt_ram			(volt_ram),
		.volt_aux			(volt_aux),
		.relay_busy			(relay_busy),
		.front_busy			(front_busy)
	);

endmodule

//--- source/mgmt_read_mux.sv
`timescale 1ns/1ps

module mgmt_read_mux
	import mgmt_regs_pkg::*;
(
	input  logic							clk,
	input  logic							reset,

	// Host read port
	input  logic							rd_en,
	input  mgmt_addr_t						rd_addr,
	output logic							rd_valid,
	output mgmt_byte_t						rd_data,

	// Device information
	input  logic							idcode_valid,
	input  logic [NUM_IDCODE_BYTES*8-1:0]	idcode,
	input  logic							die_serial_valid,
	input  logic [NUM_SERIAL_BYTES*8-1:0]	die_serial,

	// Sensors
	input  sensor_word_t					fan0_rpm,
	input  sensor_word_t					fan1_rpm,
	input  sensor_word_t					die_temp,
	input  sensor_word_t					volt_core,
	input  sensor_word_t					volt_ram,
	input  sensor_word_t					volt_aux,

	// Controller status
	input  logic							relay_busy,
	input  logic							front_busy
);

	//////////////////////////////////////////////////
	// Device info decode

	mgmt_addr_t		idcode_off;
	mgmt_addr_t		serial_off;
	logic			in_idcode;
	logic			in_serial;
	logic			wait_info;

	assign idcode_off	= rd_addr - REG_FPGA_IDCODE;
	assign serial_off	= rd_addr - REG_FPGA_SERIAL;
	assign in_idcode	= idcode_off < mgmt_addr_t'(NUM_IDCODE_BYTES);
	assign in_serial	= serial_off < mgmt_addr_t'(NUM_SERIAL_BYTES);

	// Hold off until the addressed group is valid
	assign wait_info	= (in_idcode && !idcode_valid) || (in_serial && !die_serial_valid);

	//////////////////////////////////////////////////
	// Sensor decode

	sensor_word_t	sensor_word;
	logic			sensor_hit;

	// Even address of the pair picks the word
	always_comb begin
		sensor_hit	= 1'b1;
		case ({rd_addr[ADDR_W-1:1], 1'b0})
			REG_FAN0_RPM:	sensor_word = fan0_rpm;
			REG_FAN1_RPM:	sensor_word = fan1_rpm;
			REG_DIE_TEMP:	sensor_word = die_temp;
			REG_VOLT_CORE:	sensor_word = volt_core;
			REG_VOLT_RAM:	sensor_word = volt_ram;
			REG_VOLT_AUX:	sensor_word = volt_aux;
			default: begin
				sensor_word	= '0;
				sensor_hit	= 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Byte select

	mgmt_byte_t		rd_byte;

	always_comb begin
		if (in_idcode) begin
			// Inverted offset gives MSB first
			rd_byte	= idcode[{~idcode_off[1:0], 3'b000} +: DATA_W];
		end
		else if (in_serial) begin
			rd_byte	= die_serial[{~serial_off[2:0], 3'b000} +: DATA_W];
		end
		else if (sensor_hit) begin
			// Low byte first
			rd_byte	= rd_addr[0] ? sensor_word[15:8] : sensor_word[7:0];
		end
		else begin
			// Relay stat low byte and unmapped addresses read zero
			case (rd_addr)
				REG_FRONT_STAT:		rd_byte = {{(DATA_W-1){1'b0}}, front_busy};
				REG_RELAY_STAT_1:	rd_byte = {{(DATA_W-1){1'b0}}, relay_busy};
				default:			rd_byte = '0;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Read sequencing

	logic			reading;

	always_ff @(posedge clk) begin
		if (reset) begin
			reading		<= 1'b0;
			rd_valid	<= 1'b0;
			rd_data		<= '0;
		end
		else begin
			rd_valid	<= 1'b0;

			if (rd_en)
				reading	<= 1'b1;

			// Complete now unless device info is still pending
			if ((rd_en || reading) && !wait_info) begin
				reading		<= 1'b0;
				rd_valid	<= 1'b1;
				rd_data		<= rd_byte;
			end
		end
	end

endmodule

//--- source/front_panel_control.sv
`timescale 1ns/1ps

module front_panel_control
	import mgmt_regs_pkg::*;
(
	input  logic							clk,
	input  logic							reset,

	// Decoded host writes
	input  mgmt_byte_t						wr_byte,
	input  logic							front_ctrl_wr,
	input  logic							front_data_wr,
	input  logic							led_push_wr,
	input  logic [1:0]						led_push_sel,

	// Indicator sources
	input  logic [NUM_CHANNELS-1:0]			trig_in_led,
	input  logic [NUM_CHANNELS-1:0]			trig_out_led,
	input  logic [NUM_RELAYS-1:0]			relay_state_vec,

	// Shifter interface
	output logic							front_cs_n,
	output logic							front_shift_en,
	output mgmt_byte_t						front_shift_data,
	input  logic							front_shift_done,
	output logic							front_busy
);

	//////////////////////////////////////////////////
	// LED state

	led_state_t	led_state;
	mgmt_byte_t	led_byte;

	always_comb begin
		// Input LEDs go out in reverse channel order
		for (int i = 0; i < NUM_CHANNELS; i++)
			led_state[NUM_CHANNELS+i]	= trig_in_led[NUM_CHANNELS-1-i];
		led_state[NUM_CHANNELS-1:0]		= trig_out_led;

		// Relay in input mode, keep its output LED dark
		for (int k = 0; k < NUM_RELAYS; k++) begin
			if (relay_state_vec[k])
				led_state[RELAY_FIRST_CHANNEL+k]	= 1'b0;
		end
	end

	// Byte picked by the push register
	always_comb begin
		case (led_push_sel)
			2'd0:		led_byte = led_state[0*DATA_W +: DATA_W];
			2'd1:		led_byte = led_state[1*DATA_W +: DATA_W];
			default:	led_byte = led_state[2*DATA_W +: DATA_W];
		endcase
	end

	//////////////////////////////////////////////////
	// Shifter control

	always_ff @(posedge clk) begin
		if (reset) begin
			front_cs_n		<= 1'b1;
			front_shift_en	<= 1'b0;
			front_busy		<= 1'b0;
		end
		else begin
			front_shift_en	<= front_data_wr || led_push_wr;

			if (front_ctrl_wr)
				front_cs_n	<= wr_byte[0];

			// Busy from launch until the shifter reports done
			if (front_shift_done)
				front_busy	<= 1'b0;
			if (front_shift_en)
				front_busy	<= 1'b1;
		end
	end

	// Shift payload, qualified by front_shift_en
	always_ff @(posedge clk) begin
		if (front_data_wr)
			front_shift_data	<= wr_byte;
		else if (led_push_wr)
			front_shift_data	<= led_byte;
	end

endmodule

//--- source/relay_control.sv
`timescale 1ns/1ps

module relay_control
	import mgmt_regs_pkg::*;
(
	input  logic							clk,
	input  logic							reset,

	// Decoded host writes
	input  mgmt_byte_t						wr_byte,
	input  logic							relay_chan_wr,
	input  logic							relay_toggle_wr,

	// Relay driver handshake
	output logic							relay_en,
	output relay_idx_t						relay_channel,
	output logic							relay_dir,
	input  logic							relay_done,

	// Status
	output logic							relay_busy,
	output logic [NUM_RELAYS-1:0]			relay_state_vec
);

	//////////////////////////////////////////////////
	// Command issue and state tracking

	always_ff @(posedge clk) begin
		if (reset) begin
			relay_en		<= 1'b0;
			relay_channel	<= '0;
			relay_dir		<= 1'b0;
			relay_busy		<= 1'b0;
			relay_state_vec	<= '0;
		end
		else begin
			relay_en		<= 1'b0;

			// Channel is latched ahead of the toggle
			if (relay_chan_wr)
				relay_channel	<= wr_byte[$bits(relay_idx_t)-1:0];

			// Toggle fires the command, not held off while busy
			if (relay_toggle_wr) begin
				relay_dir		<= wr_byte[DATA_W-1];
				relay_en		<= 1'b1;
			end

			// Set wins over a coincident done
			if (relay_done)
				relay_busy		<= 1'b0;
			if (relay_en)
				relay_busy		<= 1'b1;

			// Remember direction, 1 = input mode
			if (relay_en)
				relay_state_vec[relay_channel]	<= relay_dir;
		end
	end

endmodule

//--- source/mgmt_write_decoder.sv
`timescale 1ns/1ps

module mgmt_write_decoder
	import mgmt_regs_pkg::*;
(
	input  logic							clk,
	input  logic							reset,

	// Host write port
	input  logic							wr_en,
	input  mgmt_addr_t						wr_addr,
	input  mgmt_byte_t						wr_data,

	// Crossbar selectors
	output muxsel_t [NUM_CHANNELS-1:0]		muxsel,

	// Command strobes to the controllers
	output mgmt_byte_t						wr_byte,
	output logic							relay_chan_wr,
	output logic							relay_toggle_wr,
	output logic							front_ctrl_wr,
	output logic							front_data_wr,
	output logic							led_push_wr,
	output logic [1:0]						led_push_sel
);

	//////////////////////////////////////////////////
	// Address offsets into the ranged blocks

	mgmt_addr_t	led_offset;
	mgmt_addr_t	mux_offset;
	logic		mux_hit;

	// Wraps around for addresses below the base
	assign led_offset	= wr_addr - REG_FRONT_LED_0;
	assign mux_offset	= wr_addr - REG_MUXSEL_BASE;

	// Upper four selector slots are not backed by registers
	assign mux_hit		= wr_en && (mux_offset < mgmt_addr_t'(NUM_CHANNELS));

	//////////////////////////////////////////////////
	// Command strobes, valid only in the wr_en cycle

	assign wr_byte			= wr_data;

	// Relay
	assign relay_chan_wr	= wr_en && (wr_addr == REG_RELAY_TOGGLE);
	assign relay_toggle_wr	= wr_en && (wr_addr == REG_RELAY_TOGGLE_1);

	// Front panel raw access
	assign front_ctrl_wr	= wr_en && (wr_addr == REG_FRONT_CTRL);
	assign front_data_wr	= wr_en && (wr_addr == REG_FRONT_DATA);

	// LED pushes, one per byte of LED state
	assign led_push_wr		= wr_en && (led_offset < mgmt_addr_t'(NUM_LED_BYTES));
	assign led_push_sel		= led_offset[1:0];

	//////////////////////////////////////////////////
	// Selector bank

	always_ff @(posedge clk) begin
		if (reset) begin
			muxsel	<= '0;
		end
		else if (mux_hit) begin
			// Low address nibble picks the channel
			muxsel[mux_offset[CHAN_IDX_W-1:0]]	<= wr_data[MUXSEL_W-1:0];
		end
	end

endmodule

//--- source/mgmt_regs_pkg.sv
package mgmt_regs_pkg;

	//////////////////////////////////////////////////
	// Bus and datapath sizes

	// Host bus
	localparam int ADDR_W				= 16;
	localparam int DATA_W				= 8;

	// Crossbar
	localparam int NUM_CHANNELS			= 12;
	localparam int MUXSEL_W				= 4;
	localparam int CHAN_IDX_W			= $clog2(NUM_CHANNELS);

	// Relays sit on the top output channels
	localparam int NUM_RELAYS			= 4;
	localparam int RELAY_FIRST_CHANNEL	= 8;

	// Two LED bits per channel, pushed one byte at a time
	localparam int LED_W				= 24;
	localparam int NUM_LED_BYTES		= LED_W / DATA_W;

	// Device information sizes in bytes
	localparam int NUM_IDCODE_BYTES		= 4;
	localparam int NUM_SERIAL_BYTES		= 8;

	localparam int SENSOR_W				= 16;

	//////////////////////////////////////////////////
	// Shared types

	typedef logic [ADDR_W-1:0]				mgmt_addr_t;
	typedef logic [DATA_W-1:0]				mgmt_byte_t;
	typedef logic [SENSOR_W-1:0]			sensor_word_t;
	typedef logic [MUXSEL_W-1:0]			muxsel_t;
	typedef logic [$clog2(NUM_RELAYS)-1:0]	relay_idx_t;
	typedef logic [LED_W-1:0]				led_state_t;

	//////////////////////////////////////////////////
	// Register map

	// Device info, MSB first
	localparam mgmt_addr_t REG_FPGA_IDCODE		= 16'h0000;
	localparam mgmt_addr_t REG_FPGA_SERIAL		= 16'h0004;

	// Sensors, low byte at the even address
	localparam mgmt_addr_t REG_FAN0_RPM			= 16'h0010;
	localparam mgmt_addr_t REG_FAN1_RPM			= 16'h0012;
	localparam mgmt_addr_t REG_DIE_TEMP			= 16'h0014;
	localparam mgmt_addr_t REG_VOLT_CORE		= 16'h0016;
	localparam mgmt_addr_t REG_VOLT_RAM			= 16'h0018;
	localparam mgmt_addr_t REG_VOLT_AUX			= 16'h001a;

	// Front panel shifter
	localparam mgmt_addr_t REG_FRONT_CTRL		= 16'h0050;		// bit 0 = CS# level
	localparam mgmt_addr_t REG_FRONT_DATA		= 16'h0051;
	localparam mgmt_addr_t REG_FRONT_STAT		= 16'h0052;		// bit 0 = busy
	localparam mgmt_addr_t REG_FRONT_LED_0		= 16'h0053;		// LED_1, LED_2 follow

	// Relay controller
	localparam mgmt_addr_t REG_RELAY_TOGGLE		= 16'h0070;		// 1:0 = channel
	localparam mgmt_addr_t REG_RELAY_TOGGLE_1	= 16'h0071;		// 7 = direction, 1 = in
	localparam mgmt_addr_t REG_RELAY_STAT		= 16'h0072;
	localparam mgmt_addr_t REG_RELAY_STAT_1		= 16'h0073;		// bit 0 = busy

	// One selector per channel from here up
	localparam mgmt_addr_t REG_MUXSEL_BASE		= 16'h00f0;

endpackage
